//--- common/ddr3_macros.svh
/* ddr3 model widths and latencies */
`ifndef DDR3_MACROS_SVH
`define DDR3_MACROS_SVH

// bits per beat on the data bus
`define DDR3_DQ_WIDTH 8
// bank address pins
`define DDR3_BA_WIDTH 3
// row and column share these address pins
`define DDR3_A_WIDTH 13
// low row bits kept by the small array
`define DDR3_ROW_KEEP 3
// column address bits
`define DDR3_COL_WIDTH 10

// latencies in clocks
`define DDR3_AL 0
`define DDR3_CL 5
`define DDR3_CWL 5
`define DDR3_RL (`DDR3_AL + `DDR3_CL)
`define DDR3_WL (`DDR3_AL + `DDR3_CWL)

// clocks per burst, two beats per clock
`define DDR3_BL8_PAIRS 4
`define DDR3_BC4_PAIRS 2
// a12 on read or write selects bl8 when high
`define DDR3_BURST_BIT 12

// beat pair index is the column without its lowest bit
`define DDR3_PAIR_WIDTH (`DDR3_COL_WIDTH - 1)
`define DDR3_INDEX_WIDTH (`DDR3_BA_WIDTH + `DDR3_ROW_KEEP + `DDR3_PAIR_WIDTH)

`endif

//--- common/ddr3_pkg.sv
/* ddr3 model shared types */
`include "ddr3_macros.svh"

package ddr3_pkg;

	// {cs_n, ras_n, cas_n, we_n}
	// only activate, read, write and nop are acted on
	typedef enum logic [3:0] {
		CMD_MRS       = 4'b0000,
		CMD_REFRESH   = 4'b0001,
		CMD_PRECHARGE = 4'b0010,
		CMD_ACTIVATE  = 4'b0011,
		CMD_WRITE     = 4'b0100,
		CMD_READ      = 4'b0101,
		CMD_ZQC       = 4'b0110,
		CMD_NOP       = 4'b0111,
		CMD_DES       = 4'b1000
	} ddr3_cmd_e;

	// one memory word address, seen two ways
	// f: bank, kept row bits, beat pair index
	// index: flat word number for the array
	typedef union packed {
		struct packed {
			logic [`DDR3_BA_WIDTH-1:0]   bank;
			logic [`DDR3_ROW_KEEP-1:0]   row;
			logic [`DDR3_PAIR_WIDTH-1:0] pair;
		} f;
		logic [`DDR3_INDEX_WIDTH-1:0] index;
	} mem_addr_t;

endpackage

//--- logic/ddr3_cmd_decode.sv
/* ddr3 command decode and row tracking */
`timescale 1ns/1ps
`include "ddr3_macros.svh"

module ddr3_cmd_decode
	import ddr3_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      cs_n,
	input  logic                      ras_n,
	input  logic                      cas_n,
	input  logic                      we_n,
	input  logic [`DDR3_BA_WIDTH-1:0] ba,
	input  logic [`DDR3_A_WIDTH-1:0]  a,
	output logic                      rd_req,
	output logic                      wr_req,
	output logic                      req_bl8,
	output mem_addr_t                 req_addr
);

	localparam int BANKS = 2 ** `DDR3_BA_WIDTH;

	ddr3_cmd_e                 cmd_in;
	ddr3_cmd_e                 cmd_q;
	logic [`DDR3_BA_WIDTH-1:0] ba_q;
	logic [`DDR3_A_WIDTH-1:0]  a_q;
	logic [`DDR3_ROW_KEEP-1:0] row_q;
	// open row per bank
	logic [`DDR3_ROW_KEEP-1:0] row_table [BANKS];

	assign cmd_in = ddr3_cmd_e'({cs_n, ras_n, cas_n, we_n});

	// activate opens a row at its own edge
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			for (int i = 0; i < BANKS; i++)
			begin
				row_table[i] <= '0;
			end
		end
		else if (cmd_in == CMD_ACTIVATE)
		begin
			row_table[ba] <= a[`DDR3_ROW_KEEP-1:0];
		end
	end

	// command word register
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			cmd_q <= CMD_NOP;
		end
		else
		begin
			cmd_q <= cmd_in;
		end
	end

	// address captured with the command
	// row looked up at the command edge so a later activate
	// to the same bank cannot change it
	always_ff @(posedge clk)
	begin
		ba_q  <= ba;
		a_q   <= a;
		row_q <= row_table[ba];
	end

	// one clock burst request strobes
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			rd_req <= 1'b0;
			wr_req <= 1'b0;
		end
		else
		begin
			rd_req <= (cmd_q == CMD_READ);
			wr_req <= (cmd_q == CMD_WRITE);
		end
	end

	// burst length and start address valid with the strobes
	always_ff @(posedge clk)
	begin
		req_bl8           <= a_q[`DDR3_BURST_BIT];
		req_addr.f.bank   <= ba_q;
		req_addr.f.row    <= row_q;
		// one word holds a beat pair so column bit 0 is dropped
		req_addr.f.pair   <= a_q[`DDR3_COL_WIDTH-1:1];
	end

endmodule

//--- logic/latency_pipe.sv
/* burst request delay line */
`timescale 1ns/1ps

module latency_pipe
	import ddr3_pkg::*;
#(
	parameter int DEPTH = 2
)
(
	input  logic      clk,
	input  logic      reset_n,
	input  logic      in_req,
	input  logic      in_bl8,
	input  mem_addr_t in_addr,
	output logic      out_req,
	output logic      out_bl8,
	output mem_addr_t out_addr
);

	// valid bit per stage
	logic [DEPTH-1:0] req_sr;
	// payload per stage
	logic             bl8_sr  [DEPTH];
	mem_addr_t        addr_sr [DEPTH];

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			req_sr <= '0;
		end
		else
		begin
			req_sr <= {req_sr[DEPTH-2:0], in_req};
		end
	end

	// payload only moves along with a valid request
	always_ff @(posedge clk)
	begin
		if (in_req)
		begin
			bl8_sr[0]  <= in_bl8;
			addr_sr[0] <= in_addr;
		end
		for (int i = 1; i < DEPTH; i++)
		begin
			if (req_sr[i-1])
			begin
				bl8_sr[i]  <= bl8_sr[i-1];
				addr_sr[i] <= addr_sr[i-1];
			end
		end
	end

	assign out_req  = req_sr[DEPTH-1];
	assign out_bl8  = bl8_sr[DEPTH-1];
	assign out_addr = addr_sr[DEPTH-1];

endmodule

//--- logic/burst_sequencer.sv
/* beat pair burst sequencer */
`timescale 1ns/1ps
`include "ddr3_macros.svh"

module burst_sequencer
	import ddr3_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,
	input  logic      start,
	input  logic      bl8,
	input  mem_addr_t base_addr,
	output logic      beat_active,
	output mem_addr_t beat_addr
);

	localparam int PAIR_W = `DDR3_PAIR_WIDTH;

	// pair states double as the pair count
	localparam logic [2:0] ST_PAIR0 = 3'd0;
	localparam logic [2:0] ST_PAIR1 = 3'd1;
	localparam logic [2:0] ST_PAIR2 = 3'd2;
	localparam logic [2:0] ST_PAIR3 = 3'd3;
	localparam logic [2:0] ST_IDLE  = 3'd4;

	logic [2:0] state;
	logic       bl8_q;
	mem_addr_t  base_q;
	logic [1:0] pair_cnt;
	logic       last_pair;
	logic       accept;

	assign pair_cnt = state[1:0];

	// bl8 ends on pair 3, bc4 on pair 1
	assign last_pair = (state != ST_IDLE) &&
		(pair_cnt == (bl8_q ? 2'(`DDR3_BL8_PAIRS - 1) : 2'(`DDR3_BC4_PAIRS - 1)));

	// a start is taken from idle or chained onto the last pair
	assign accept = start && ((state == ST_IDLE) || last_pair);

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state <= ST_IDLE;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (start)
					begin
						state <= ST_PAIR0;
					end
				end
				ST_PAIR0, ST_PAIR1, ST_PAIR2, ST_PAIR3:
				begin
					if (last_pair)
					begin
						// back to back burst, no gap
						state <= start ? ST_PAIR0 : ST_IDLE;
					end
					else
					begin
						state <= state + 3'd1;
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// burst parameters held for the whole burst
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			bl8_q  <= bl8;
			base_q <= base_addr;
		end
	end

	assign beat_active = (state != ST_IDLE);

	// bank and row fixed, pair index steps once per clock
	always_comb
	begin
		beat_addr        = base_q;
		beat_addr.f.pair = base_q.f.pair + PAIR_W'(pair_cnt);
	end

	// commands closer than one burst apart
	a_start_window: assert property (@(posedge clk) disable iff (!reset_n)
		start |-> ((state == ST_IDLE) || last_pair));

endmodule

//--- logic/beat_pair_ram.sv
/* beat pair memory array */
`timescale 1ns/1ps
`include "ddr3_macros.svh"

module beat_pair_ram
	import ddr3_pkg::*;
(
	input  logic                      clk,
	input  logic                      wr_en,
	input  mem_addr_t                 wr_addr,
	input  logic [`DDR3_DQ_WIDTH-1:0] wr_data_lo,
	input  logic [`DDR3_DQ_WIDTH-1:0] wr_data_hi,
	input  logic                      wr_mask_lo,
	input  logic                      wr_mask_hi,
	input  mem_addr_t                 rd_addr,
	output logic [`DDR3_DQ_WIDTH-1:0] rd_data_lo,
	output logic [`DDR3_DQ_WIDTH-1:0] rd_data_hi
);

	localparam int WORDS = 2 ** `DDR3_INDEX_WIDTH;

	// one lane per beat of the pair
	logic [`DDR3_DQ_WIDTH-1:0] lane_lo [WORDS];
	logic [`DDR3_DQ_WIDTH-1:0] lane_hi [WORDS];

	// write port, mask high keeps the old byte
	always_ff @(posedge clk)
	begin
		if (wr_en && !wr_mask_lo)
		begin
			lane_lo[wr_addr.index] <= wr_data_lo;
		end
		if (wr_en && !wr_mask_hi)
		begin
			lane_hi[wr_addr.index] <= wr_data_hi;
		end
	end

	// read port, registered every clock
	// same address as a write gives the old word
	always_ff @(posedge clk)
	begin
		rd_data_lo <= lane_lo[rd_addr.index];
		rd_data_hi <= lane_hi[rd_addr.index];
	end

endmodule

//--- ddr3_model/ddr3_model_top.sv
/* ddr3 beat pair memory model */
`timescale 1ns/1ps
`include "ddr3_macros.svh"

module ddr3_model_top
	import ddr3_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      cs_n,
	input  logic                      ras_n,
	input  logic                      cas_n,
	input  logic                      we_n,
	input  logic [`DDR3_BA_WIDTH-1:0] ba,
	input  logic [`DDR3_A_WIDTH-1:0]  a,
	input  logic [`DDR3_DQ_WIDTH-1:0] wr_data_lo,
	input  logic [`DDR3_DQ_WIDTH-1:0] wr_data_hi,
	input  logic                      wr_mask_lo,
	input  logic                      wr_mask_hi,
	output logic [`DDR3_DQ_WIDTH-1:0] rd_data_lo,
	output logic [`DDR3_DQ_WIDTH-1:0] rd_data_hi,
	output logic                      rd_valid
);

	// decoder takes 2 clocks and the sequencer 1 before the ram edge
	// read data leaves the ram register at that edge
	// and write data is taken by the ram at that edge
	localparam int RD_PIPE_DEPTH = `DDR3_RL - 3;
	localparam int WR_PIPE_DEPTH = `DDR3_WL - 3;

	logic      rd_req;
	logic      wr_req;
	logic      req_bl8;
	mem_addr_t req_addr;
	logic      rd_pipe_req;
	logic      rd_pipe_bl8;
	mem_addr_t rd_pipe_addr;
	logic      wr_pipe_req;
	logic      wr_pipe_bl8;
	mem_addr_t wr_pipe_addr;
	logic      rd_beat_active;
	mem_addr_t rd_beat_addr;
	logic      wr_beat_active;
	mem_addr_t wr_beat_addr;

	ddr3_cmd_decode cmd_decode (
		.clk      (clk),
		.reset_n  (reset_n),
		.cs_n     (cs_n),
		.ras_n    (ras_n),
		.cas_n    (cas_n),
		.we_n     (we_n),
		.ba       (ba),
		.a        (a),
		.rd_req   (rd_req),
		.wr_req   (wr_req),
		.req_bl8  (req_bl8),
		.req_addr (req_addr)
	);

	// read latency
	latency_pipe #(.DEPTH(RD_PIPE_DEPTH)) read_pipe (
		.clk      (clk),
		.reset_n  (reset_n),
		.in_req   (rd_req),
		.in_bl8   (req_bl8),
		.in_addr  (req_addr),
		.out_req  (rd_pipe_req),
		.out_bl8  (rd_pipe_bl8),
		.out_addr (rd_pipe_addr)
	);

	// write latency
	latency_pipe #(.DEPTH(WR_PIPE_DEPTH)) write_pipe (
		.clk      (clk),
		.reset_n  (reset_n),
		.in_req   (wr_req),
		.in_bl8   (req_bl8),
		.in_addr  (req_addr),
		.out_req  (wr_pipe_req),
		.out_bl8  (wr_pipe_bl8),
		.out_addr (wr_pipe_addr)
	);

	burst_sequencer read_seq (
		.clk         (clk),
		.reset_n     (reset_n),
		.start       (rd_pipe_req),
		.bl8         (rd_pipe_bl8),
		.base_addr   (rd_pipe_addr),
		.beat_active (rd_beat_active),
		.beat_addr   (rd_beat_addr)
	);

	burst_sequencer write_seq (
		.clk         (clk),
		.reset_n     (reset_n),
		.start       (wr_pipe_req),
		.bl8         (wr_pipe_bl8),
		.base_addr   (wr_pipe_addr),
		.beat_active (wr_beat_active),
		.beat_addr   (wr_beat_addr)
	);

	// write port fed straight from the write sequencer
	beat_pair_ram ram (
		.clk        (clk),
		.wr_en      (wr_beat_active),
		.wr_addr    (wr_beat_addr),
		.wr_data_lo (wr_data_lo),
		.wr_data_hi (wr_data_hi),
		.wr_mask_lo (wr_mask_lo),
		.wr_mask_hi (wr_mask_hi),
		.rd_addr    (rd_beat_addr),
		.rd_data_lo (rd_data_lo),
		.rd_data_hi (rd_data_hi)
	);

	// valid lines up with the ram read register
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			rd_valid <= 1'b0;
		end
		else
		begin
			rd_valid <= rd_beat_active;
		end
	end

endmodule

//--- verification/tb_ddr3_table.svh
/* ddr3 model test operations */
`ifndef TB_DDR3_TABLE_SVH
`define TB_DDR3_TABLE_SVH

	typedef enum logic [1:0] {
		OP_ACT,
		OP_WR,
		OP_RD
	} op_kind_e;

	typedef struct packed {
		op_kind_e                  kind;
		logic [`DDR3_BA_WIDTH-1:0] bank;
		logic [`DDR3_A_WIDTH-1:0]  row;
		logic [9:0]                col;
		logic                      bl8;
		// bit n masks beat pair n
		logic [3:0]                mask_lo;
		logic [3:0]                mask_hi;
		logic [7:0]                wait_clks;
	} op_t;

	op_t ops [MAX_OPS];
	int  num_ops = 0;

	task automatic add_op(input op_kind_e kind, input int bank, input int row, input int col,
		input int bl8, input int mask_lo, input int mask_hi, input int wait_clks);
		op_t op;
		op.kind      = kind;
		op.bank      = `DDR3_BA_WIDTH'(bank);
		op.row       = `DDR3_A_WIDTH'(row);
		op.col       = 10'(col);
		op.bl8       = 1'(bl8);
		op.mask_lo   = 4'(mask_lo);
		op.mask_hi   = 4'(mask_hi);
		op.wait_clks = 8'(wait_clks);
		ops[num_ops] = op;
		num_ops++;
	endtask

	// columns: kind, bank, row, column, bl8, lo masks, hi masks, clocks to next command
	task automatic load_ops();
		// bl8 write then read back
		add_op(OP_ACT, 0, 3, 0, 0, 4'b0000, 4'b0000, 1);
		add_op(OP_WR, 0, 0, 16, 1, 4'b0000, 4'b0000, 6);
		add_op(OP_RD, 0, 0, 16, 1, 4'b0000, 4'b0000, 12);
		// chopped write, pairs 2 and 3 keep old data
		add_op(OP_WR, 0, 0, 16, 0, 4'b0000, 4'b0000, 6);
		add_op(OP_RD, 0, 0, 16, 1, 4'b0000, 4'b0000, 10);
		add_op(OP_RD, 0, 0, 16, 0, 4'b0000, 4'b0000, 8);
		// byte masks
		add_op(OP_WR, 0, 0, 16, 1, 4'b0101, 4'b1010, 6);
		add_op(OP_RD, 0, 0, 16, 1, 4'b0000, 4'b0000, 10);
		// same column in two rows and two banks
		add_op(OP_WR, 0, 0, 40, 1, 4'b0000, 4'b0000, 6);
		add_op(OP_ACT, 0, 6, 0, 0, 4'b0000, 4'b0000, 1);
		add_op(OP_WR, 0, 0, 40, 1, 4'b0000, 4'b0000, 6);
		add_op(OP_ACT, 1, 3, 0, 0, 4'b0000, 4'b0000, 1);
		add_op(OP_WR, 1, 0, 40, 1, 4'b0000, 4'b0000, 6);
		add_op(OP_RD, 0, 0, 40, 1, 4'b0000, 4'b0000, 5);
		add_op(OP_ACT, 0, 3, 0, 0, 4'b0000, 4'b0000, 1);
		add_op(OP_RD, 0, 0, 40, 1, 4'b0000, 4'b0000, 5);
		add_op(OP_RD, 1, 0, 40, 1, 4'b0000, 4'b0000, 10);
		// back to back bursts, four clocks apart
		add_op(OP_ACT, 2, 1, 0, 0, 4'b0000, 4'b0000, 1);
		add_op(OP_WR, 2, 0, 64, 1, 4'b0000, 4'b0000, 4);
		add_op(OP_WR, 2, 0, 72, 1, 4'b0000, 4'b0000, 8);
		add_op(OP_RD, 2, 0, 64, 1, 4'b0000, 4'b0000, 4);
		add_op(OP_RD, 2, 0, 72, 1, 4'b0000, 4'b0000, 12);
		// odd column lands on the same beat pair
		add_op(OP_RD, 0, 0, 17, 1, 4'b0000, 4'b0000, 10);
	endtask

`endif

//--- verification/tb_ddr3_model.sv
/* ddr3 model testbench */
`timescale 1ns/1ps
`include "ddr3_macros.svh"

module tb_ddr3_model;

	localparam int HALF_PERIOD  = 10;
	localparam int RESET_CYCLES = 4;
	localparam int SCHED_LEN    = 1024;
	localparam int MAX_OPS      = 64;
	localparam int DQ           = `DDR3_DQ_WIDTH;
	localparam int BANKS        = 2 ** `DDR3_BA_WIDTH;
	localparam int ROWS         = 2 ** `DDR3_ROW_KEEP;
	localparam int PAIRS        = 2 ** (`DDR3_COL_WIDTH - 1);
	localparam logic [15:0] LFSR_SEED = 16'd64268;

	logic                      clk = 1'b0;
	logic                      reset_n;
	logic                      cs_n;
	logic                      ras_n;
	logic                      cas_n;
	logic                      we_n;
	logic [`DDR3_BA_WIDTH-1:0] ba;
	logic [`DDR3_A_WIDTH-1:0]  a;
	logic [DQ-1:0]             wr_data_lo;
	logic [DQ-1:0]             wr_data_hi;
	logic                      wr_mask_lo;
	logic                      wr_mask_hi;
	logic [DQ-1:0]             rd_data_lo;
	logic [DQ-1:0]             rd_data_hi;
	logic                      rd_valid;

	`include "tb_ddr3_table.svh"

	// reference memory words are {hi, lo}
	logic [15:0]               ref_mem [BANKS][ROWS][PAIRS];
	logic [`DDR3_ROW_KEEP-1:0] open_row [BANKS];

	// per rising edge the write data to present and the read data to expect
	// idle clocks carry unmasked zero data
	logic [DQ-1:0] sched_lo [SCHED_LEN];
	logic [DQ-1:0] sched_hi [SCHED_LEN];
	logic          sched_mlo [SCHED_LEN];
	logic          sched_mhi [SCHED_LEN];
	logic          exp_valid [SCHED_LEN];
	logic [DQ-1:0] exp_lo [SCHED_LEN];
	logic [DQ-1:0] exp_hi [SCHED_LEN];

	logic [15:0] lfsr;
	int          cyc = 0;
	int          limit;
	int          errors = 0;
	int          checks = 0;

	ddr3_model_top UUT (
		.clk        (clk),
		.reset_n    (reset_n),
		.cs_n       (cs_n),
		.ras_n      (ras_n),
		.cas_n      (cas_n),
		.we_n       (we_n),
		.ba         (ba),
		.a          (a),
		.wr_data_lo (wr_data_lo),
		.wr_data_hi (wr_data_hi),
		.wr_mask_lo (wr_mask_lo),
		.wr_mask_hi (wr_mask_hi),
		.rd_data_lo (rd_data_lo),
		.rd_data_hi (rd_data_hi),
		.rd_valid   (rd_valid)
	);

	always #HALF_PERIOD clk = ~clk;

	// rising edge count and watchdog
	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		if (cyc >= limit)
		begin
			$display("timeout: run did not finish within %0d clocks", limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// one lfsr step per bit
	task automatic random_byte(output logic [DQ-1:0] b);
		b = '0;
		for (int i = 0; i < DQ; i++)
		begin
			lfsr = lfsr_next(lfsr);
			b = {b[DQ-2:0], lfsr[0]};
		end
	endtask

	task automatic compare(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// check what the last rising edge produced
	// then set up the inputs for the next one
	task automatic next_clock();
		@(negedge clk);
		compare("rd_valid", 16'(rd_valid), 16'(exp_valid[cyc]));
		if (exp_valid[cyc])
		begin
			compare("rd_data_lo", 16'(rd_data_lo), 16'(exp_lo[cyc]));
			compare("rd_data_hi", 16'(rd_data_hi), 16'(exp_hi[cyc]));
		end
		// nop
		{cs_n, ras_n, cas_n, we_n} = 4'b0111;
		ba = '0;
		a = '0;
		wr_data_lo = sched_lo[cyc + 1];
		wr_data_hi = sched_hi[cyc + 1];
		wr_mask_lo = sched_mlo[cyc + 1];
		wr_mask_hi = sched_mhi[cyc + 1];
	endtask

	// drive one command for the next rising edge t
	task automatic issue_op(input op_t op);
		int                        t;
		int                        pairs;
		logic [`DDR3_ROW_KEEP-1:0] row;
		logic [8:0]                pair;
		logic [DQ-1:0]             lo;
		logic [DQ-1:0]             hi;
		logic [15:0]               word;
		t = cyc + 1;
		pairs = op.bl8 ? `DDR3_BL8_PAIRS : `DDR3_BC4_PAIRS;
		row = open_row[op.bank];
		ba = op.bank;
		a = '0;
		a[`DDR3_BURST_BIT] = op.bl8;
		a[9:0] = op.col;
		case (op.kind)
			OP_ACT:
			begin
				{cs_n, ras_n, cas_n, we_n} = 4'b0011;
				a = op.row;
				open_row[op.bank] = op.row[`DDR3_ROW_KEEP-1:0];
			end
			OP_WR:
			begin
				{cs_n, ras_n, cas_n, we_n} = 4'b0100;
				for (int p = 0; p < pairs; p++)
				begin
					pair = op.col[9:1] + 9'(p);
					random_byte(lo);
					random_byte(hi);
					sched_lo[t + `DDR3_WL + p] = lo;
					sched_hi[t + `DDR3_WL + p] = hi;
					sched_mlo[t + `DDR3_WL + p] = op.mask_lo[p];
					sched_mhi[t + `DDR3_WL + p] = op.mask_hi[p];
					// masked bytes keep the old value
					word = ref_mem[op.bank][row][pair];
					if (!op.mask_lo[p])
					begin
						word[7:0] = lo;
					end
					if (!op.mask_hi[p])
					begin
						word[15:8] = hi;
					end
					ref_mem[op.bank][row][pair] = word;
				end
			end
			default:
			begin
				{cs_n, ras_n, cas_n, we_n} = 4'b0101;
				for (int p = 0; p < pairs; p++)
				begin
					pair = op.col[9:1] + 9'(p);
					word = ref_mem[op.bank][row][pair];
					exp_valid[t + `DDR3_RL + p] = 1'b1;
					exp_lo[t + `DDR3_RL + p] = word[7:0];
					exp_hi[t + `DDR3_RL + p] = word[15:8];
				end
			end
		endcase
	endtask

	initial
	begin
		reset_n = 1'b0;
		{cs_n, ras_n, cas_n, we_n} = 4'b1111;
		ba = '0;
		a = '0;
		wr_data_lo = '0;
		wr_data_hi = '0;
		wr_mask_lo = 1'b0;
		wr_mask_hi = 1'b0;
		lfsr = LFSR_SEED;
		for (int i = 0; i < SCHED_LEN; i++)
		begin
			sched_lo[i] = '0;
			sched_hi[i] = '0;
			sched_mlo[i] = 1'b0;
			sched_mhi[i] = 1'b0;
			exp_valid[i] = 1'b0;
			exp_lo[i] = '0;
			exp_hi[i] = '0;
		end
		for (int b = 0; b < BANKS; b++)
		begin
			open_row[b] = '0;
		end
		load_ops();
		// sum of the waits plus read latency plus margin
		limit = `DDR3_RL + 20;
		for (int i = 0; i < num_ops; i++)
		begin
			limit += int'(ops[i].wait_clks);
		end
		// rd_valid stays low while in reset
		repeat (RESET_CYCLES)
		begin
			@(negedge clk);
			compare("rd_valid", 16'(rd_valid), 16'h0000);
		end
		reset_n = 1'b1;
		for (int i = 0; i < num_ops; i++)
		begin
			issue_op(ops[i]);
			repeat (ops[i].wait_clks) next_clock();
		end
		// drain the last burst
		repeat (`DDR3_RL + `DDR3_BL8_PAIRS + 2) next_clock();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Simulation finished: PASS");
		end
		else
		begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+common
+incdir+verification
common/ddr3_pkg.sv
logic/ddr3_cmd_decode.sv
logic/latency_pipe.sv
logic/burst_sequencer.sv
logic/beat_pair_ram.sv
ddr3_model/ddr3_model_top.sv
verification/tb_ddr3_model.sv

//--- Makefile
# Verilator build and run of the ddr3 model testbench

SIM      = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = tb_ddr3_model
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
